// ==== aes_wrap_pkg.sv ====
package aes_wrap_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int DATA_W         = 32;
  localparam int ADDR_W         = 8;
  localparam int KV_ENTRY_W     = 5;
  localparam int NUM_SEED_WORDS = 9;
  localparam int KEY_WORDS      = 8;
  localparam int DATA_IN_WORDS  = 4;

  // Bus word and byte address
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Full seed, word 0 in the low bits
  typedef logic [NUM_SEED_WORDS*DATA_W-1:0] seed_t;

  // Sideload key, word 0 in the low bits
  typedef logic [KEY_WORDS*DATA_W-1:0] key_t;

  // Key-vault slot index
  typedef logic [KV_ENTRY_W-1:0] kv_entry_t;

  // ==================================================
  // Register map
  // ==================================================
  // Bit 0 enables the data-in byte swap
  localparam addr_t ADDR_CTRL0         = 8'h00;
  // Bit 0 read enable, bits 5:1 entry
  localparam addr_t ADDR_KEY_CTRL      = 8'h04;
  // Bit 0 ready, bit 1 valid
  localparam addr_t ADDR_KEY_STATUS    = 8'h08;
  localparam addr_t ADDR_DATA_IN0      = 8'h10;
  localparam addr_t ADDR_DATA_IN_LAST  = 8'h1C;
  localparam addr_t ADDR_SEED0         = 8'h20;
  localparam addr_t ADDR_SEED_LAST     = 8'h40;

  // Single-cycle request, no hold
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } cif_req_t;

  typedef struct packed {
    word_t rdata;
    logic  error;
  } cif_rsp_t;

endpackage

// ==== aes_req_mux.sv ====
`timescale 1ns/1ps

module aes_req_mux (
  input  aes_wrap_pkg::cif_req_t host_req_i,
  input  aes_wrap_pkg::cif_req_t dma_req_i,
  input  logic                   endian_swap_i,
  input  aes_wrap_pkg::word_t    reg_rdata_i,
  output aes_wrap_pkg::cif_rsp_t host_rsp_o,
  output aes_wrap_pkg::cif_rsp_t dma_rsp_o,
  output aes_wrap_pkg::cif_req_t reg_req_o
);
  import aes_wrap_pkg::*;

  localparam int NUM_BYTES = DATA_W / 8;

  cif_req_t sel_req;
  logic     collision;
  logic     in_data_window;
  logic     swap_en;
  word_t    rdata_out;

  // Reverse byte order within one word
  function automatic word_t byte_rev(input word_t w);
    word_t r;
    for (int b = 0; b < NUM_BYTES; b++) begin
      r[b*8 +: 8] = w[(NUM_BYTES-1-b)*8 +: 8];
    end
    return r;
  endfunction

  // ==================================================
  // Request merge
  // ==================================================
  // DMA wins when both ports ask
  assign sel_req   = dma_req_i.valid ? dma_req_i : host_req_i;
  assign collision = dma_req_i.valid && host_req_i.valid;

  // Swap only inside the data-in window
  assign in_data_window = (sel_req.addr >= ADDR_DATA_IN0) &&
                          (sel_req.addr <= ADDR_DATA_IN_LAST);
  assign swap_en = sel_req.valid && endian_swap_i && in_data_window;

  always_comb begin
    reg_req_o       = sel_req;
    reg_req_o.wdata = swap_en ? byte_rev(sel_req.wdata) : sel_req.wdata;
  end

  // Read data back out, same swap decision
  assign rdata_out = swap_en ? byte_rev(reg_rdata_i) : reg_rdata_i;

  // ==================================================
  // Responses
  // ==================================================
  always_comb begin
    dma_rsp_o.rdata  = dma_req_i.valid ? rdata_out : '0;
    dma_rsp_o.error  = collision;
    // Host gets data only when its request was the one served
    host_rsp_o.rdata = (host_req_i.valid && !dma_req_i.valid) ? rdata_out : '0;
    host_rsp_o.error = collision;
  end

endmodule

// ==== aes_wrap_regs.sv ====
`timescale 1ns/1ps

module aes_wrap_regs #(
  parameter int NUM_SEED = aes_wrap_pkg::NUM_SEED_WORDS
) (
  input  logic                      clk,
  input  logic                      reset_n,
  input  aes_wrap_pkg::cif_req_t    reg_req_i,
  input  logic                      kv_ready_i,
  input  logic                      key_done_i,
  output aes_wrap_pkg::word_t       reg_rdata_o,
  output logic                      endian_swap_o,
  output logic                      key_read_en_o,
  output aes_wrap_pkg::kv_entry_t   key_read_entry_o,
  output logic [NUM_SEED-1:0]       seed_wr_o,
  output aes_wrap_pkg::seed_t       seed_state_o
);
  import aes_wrap_pkg::*;

  logic       wr_en;
  logic       ctrl0_hit;
  logic       key_ctrl_hit;
  logic       key_status_hit;
  logic       data_in_hit;
  logic       seed_hit;
  logic [1:0] data_in_idx;
  logic [3:0] seed_idx;

  logic       swap_q;
  logic       read_en_q;
  kv_entry_t  entry_q;
  logic       key_valid_q;
  word_t      data_in_q [DATA_IN_WORDS];
  seed_t      seed_q;

  // ==================================================
  // Address decode
  // ==================================================
  assign wr_en          = reg_req_i.valid && reg_req_i.write;
  assign ctrl0_hit      = reg_req_i.addr == ADDR_CTRL0;
  assign key_ctrl_hit   = reg_req_i.addr == ADDR_KEY_CTRL;
  assign key_status_hit = reg_req_i.addr == ADDR_KEY_STATUS;
  // Word-aligned windows only
  assign data_in_hit = (reg_req_i.addr >= ADDR_DATA_IN0) &&
                       (reg_req_i.addr <= ADDR_DATA_IN_LAST) &&
                       (reg_req_i.addr[1:0] == 2'b00);
  assign seed_hit    = (reg_req_i.addr >= ADDR_SEED0) &&
                       (reg_req_i.addr <= ADDR_SEED_LAST) &&
                       (reg_req_i.addr[1:0] == 2'b00);
  assign data_in_idx = reg_req_i.addr[3:2];
  assign seed_idx    = 4'((reg_req_i.addr - ADDR_SEED0) >> 2);

  // Control and key status
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      swap_q      <= 1'b0;
      read_en_q   <= 1'b0;
      entry_q     <= '0;
      key_valid_q <= 1'b0;
    end else begin
      // Read enable dropped while the loader is busy
      read_en_q <= wr_en && key_ctrl_hit && reg_req_i.wdata[0] && kv_ready_i;
      if (wr_en && ctrl0_hit) begin
        swap_q <= reg_req_i.wdata[0];
      end
      if (wr_en && key_ctrl_hit && kv_ready_i) begin
        entry_q <= reg_req_i.wdata[KV_ENTRY_W:1];
      end
      // New request clears valid, done sets it
      if (read_en_q) begin
        key_valid_q <= 1'b0;
      end else if (key_done_i) begin
        key_valid_q <= 1'b1;
      end
    end
  end

  // Data-in and seed storage
  always_ff @(posedge clk) begin
    if (wr_en && data_in_hit) begin
      data_in_q[data_in_idx] <= reg_req_i.wdata;
    end
    if (wr_en && seed_hit) begin
      seed_q[seed_idx*DATA_W +: DATA_W] <= reg_req_i.wdata;
    end
  end

  // One strobe bit per seed word written this cycle
  always_comb begin
    for (int i = 0; i < NUM_SEED; i++) begin
      seed_wr_o[i] = wr_en && seed_hit && (seed_idx == i);
    end
  end

  // ==================================================
  // Read mux
  // ==================================================
  always_comb begin
    reg_rdata_o = '0;
    if (ctrl0_hit) begin
      reg_rdata_o = word_t'(swap_q);
    end else if (key_ctrl_hit) begin
      reg_rdata_o = word_t'({entry_q, read_en_q});
    end else if (key_status_hit) begin
      reg_rdata_o = word_t'({key_valid_q, kv_ready_i});
    end else if (data_in_hit) begin
      reg_rdata_o = data_in_q[data_in_idx];
    end else if (seed_hit) begin
      reg_rdata_o = seed_q[seed_idx*DATA_W +: DATA_W];
    end
  end

  assign endian_swap_o    = swap_q;
  assign key_read_en_o    = read_en_q;
  assign key_read_entry_o = entry_q;
  assign seed_state_o     = seed_q;

endmodule

// ==== aes_seed_tracker.sv ====
`timescale 1ns/1ps

module aes_seed_tracker #(
  parameter int NUM_WORDS = aes_wrap_pkg::NUM_SEED_WORDS
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [NUM_WORDS-1:0] seed_wr_i,
  input  aes_wrap_pkg::seed_t  seed_state_i,
  output logic                 seed_load_o,
  output aes_wrap_pkg::seed_t  seed_o
);
  import aes_wrap_pkg::*;

  logic [NUM_WORDS-1:0] written_q;
  logic                 all_written;
  logic                 load_q;
  seed_t                seed_q;

  // Every word seen at least once
  assign all_written = &written_q;

  // Flags restart when the load fires, a write that cycle is dropped
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      written_q <= '0;
      load_q    <= 1'b0;
    end else begin
      written_q <= all_written ? '0 : (written_q | seed_wr_i);
      load_q    <= all_written;
    end
  end

  // Snapshot so the seed holds during the load pulse
  always_ff @(posedge clk) begin
    if (all_written) begin
      seed_q <= seed_state_i;
    end
  end

  assign seed_load_o = load_q;
  assign seed_o      = seed_q;

endmodule

// ==== aes_key_loader.sv ====
`timescale 1ns/1ps

module aes_key_loader #(
  parameter int NUM_KEY_WORDS = aes_wrap_pkg::KEY_WORDS
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    clear_secrets_i,
  input  logic                    key_read_en_i,
  input  aes_wrap_pkg::kv_entry_t key_read_entry_i,
  input  logic                    kv_wr_en_i,
  input  logic [2:0]              kv_offset_i,
  input  aes_wrap_pkg::word_t     kv_data_i,
  input  logic                    kv_done_i,
  output logic                    kv_req_o,
  output aes_wrap_pkg::kv_entry_t kv_entry_o,
  output logic                    kv_ready_o,
  output logic                    key_done_o,
  output logic                    key_valid_o,
  output aes_wrap_pkg::key_t      key_o
);
  import aes_wrap_pkg::*;

  localparam int NUM_BYTES = DATA_W / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_LOAD
  } state_e;

  state_e    state_q;
  kv_entry_t entry_q;
  logic [NUM_KEY_WORDS-1:0][NUM_BYTES-1:0][7:0] capture_q;
  logic [NUM_KEY_WORDS-1:0][NUM_BYTES-1:0][7:0] capture_d;
  logic      key_valid_q;
  key_t      key_q;

  // ==================================================
  // Request FSM
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_IDLE;
      entry_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (key_read_en_i) begin
            entry_q <= key_read_entry_i;
            state_q <= ST_REQ;
          end
        end
        // Single request cycle to the vault
        ST_REQ:  state_q <= ST_LOAD;
        // Stream length varies, done ends it
        ST_LOAD: begin
          if (kv_done_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign kv_req_o   = state_q == ST_REQ;
  assign kv_entry_o = entry_q;
  assign kv_ready_o = state_q == ST_IDLE;
  assign key_done_o = (state_q == ST_LOAD) && kv_done_i;

  // Byte b of the stored word comes from byte 3-b of the vault word
  always_comb begin
    capture_d = capture_q;
    if (kv_wr_en_i && (state_q == ST_LOAD)) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        capture_d[kv_offset_i][b] = kv_data_i[(NUM_BYTES-1-b)*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      capture_q <= '0;
    end else if (clear_secrets_i) begin
      capture_q <= '0;
    end else begin
      capture_q <= capture_d;
    end
  end

  // ==================================================
  // Sideload key
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_valid_q <= 1'b0;
      key_q       <= '0;
    end else if (key_read_en_i || clear_secrets_i) begin
      // Old key invalid on a new request or a wipe
      key_valid_q <= 1'b0;
      key_q       <= '0;
    end else if (key_done_o) begin
      key_valid_q <= 1'b1;
      key_q       <= capture_d;
    end
  end

  assign key_valid_o = key_valid_q;
  assign key_o       = key_q;

endmodule

// ==== aes_wrap_top.sv ====
`timescale 1ns/1ps

module aes_wrap_top #(
  parameter int NUM_SEED_WORDS = aes_wrap_pkg::NUM_SEED_WORDS,
  parameter int KEY_WORDS      = aes_wrap_pkg::KEY_WORDS
) (
  input  logic                    clk,
  input  logic                    reset_n,
  // Register ports
  input  aes_wrap_pkg::cif_req_t  host_req_i,
  output aes_wrap_pkg::cif_rsp_t  host_rsp_o,
  input  aes_wrap_pkg::cif_req_t  dma_req_i,
  output aes_wrap_pkg::cif_rsp_t  dma_rsp_o,
  // Key vault
  input  logic                    clear_secrets_i,
  output logic                    kv_req_o,
  output aes_wrap_pkg::kv_entry_t kv_entry_o,
  input  logic                    kv_wr_en_i,
  input  logic [2:0]              kv_offset_i,
  input  aes_wrap_pkg::word_t     kv_data_i,
  input  logic                    kv_done_i,
  // Sideload key and seed
  output logic                    key_valid_o,
  output aes_wrap_pkg::key_t      key_o,
  output logic                    seed_load_o,
  output aes_wrap_pkg::seed_t     seed_o
);
  import aes_wrap_pkg::*;

  cif_req_t                reg_req;
  word_t                   reg_rdata;
  logic                    endian_swap;
  logic                    key_read_en;
  kv_entry_t               key_read_entry;
  logic                    kv_ready;
  logic                    key_done;
  logic [NUM_SEED_WORDS-1:0] seed_wr;
  seed_t                   seed_state;

  aes_req_mux u_req_mux (
    .host_req_i    (host_req_i),
    .dma_req_i     (dma_req_i),
    .endian_swap_i (endian_swap),
    .reg_rdata_i   (reg_rdata),
    .host_rsp_o    (host_rsp_o),
    .dma_rsp_o     (dma_rsp_o),
    .reg_req_o     (reg_req)
  );

  aes_wrap_regs #(
    .NUM_SEED (NUM_SEED_WORDS)
  ) u_regs (
    .clk              (clk),
    .reset_n          (reset_n),
    .reg_req_i        (reg_req),
    .kv_ready_i       (kv_ready),
    .key_done_i       (key_done),
    .reg_rdata_o      (reg_rdata),
    .endian_swap_o    (endian_swap),
    .key_read_en_o    (key_read_en),
    .key_read_entry_o (key_read_entry),
    .seed_wr_o        (seed_wr),
    .seed_state_o     (seed_state)
  );

  aes_seed_tracker #(
    .NUM_WORDS (NUM_SEED_WORDS)
  ) u_seed_tracker (
    .clk          (clk),
    .reset_n      (reset_n),
    .seed_wr_i    (seed_wr),
    .seed_state_i (seed_state),
    .seed_load_o  (seed_load_o),
    .seed_o       (seed_o)
  );

  aes_key_loader #(
    .NUM_KEY_WORDS (KEY_WORDS)
  ) u_key_loader (
    .clk              (clk),
    .reset_n          (reset_n),
    .clear_secrets_i  (clear_secrets_i),
    .key_read_en_i    (key_read_en),
    .key_read_entry_i (key_read_entry),
    .kv_wr_en_i       (kv_wr_en_i),
    .kv_offset_i      (kv_offset_i),
    .kv_data_i        (kv_data_i),
    .kv_done_i        (kv_done_i),
    .kv_req_o         (kv_req_o),
    .kv_entry_o       (kv_entry_o),
    .kv_ready_o       (kv_ready),
    .key_done_o       (key_done),
    .key_valid_o      (key_valid_o),
    .key_o            (key_o)
  );

endmodule

// ==== tb_aes_wrap_assertions.sv ====
`timescale 1ns/1ps

module tb_aes_wrap_assertions (
  input logic clk,
  input logic reset_n,
  input logic seed_load_i,
  input logic kv_req_i,
  input logic key_valid_i,
  input logic clear_secrets_i
);

  // Seed load is a one-cycle strobe
  seed_load_single: assert property (
    @(posedge clk) disable iff (!reset_n) seed_load_i |=> !seed_load_i
  ) else $error("seed_load_o stayed high for a second cycle");

  // Vault request lasts exactly one cycle
  kv_req_single: assert property (
    @(posedge clk) disable iff (!reset_n) kv_req_i |=> !kv_req_i
  ) else $error("kv_req_o stayed high for a second cycle");

  // Wipe drops the sideload key on the next edge
  clear_drops_valid: assert property (
    @(posedge clk) disable iff (!reset_n) clear_secrets_i |=> !key_valid_i
  ) else $error("key_valid_o still high one cycle after clear_secrets_i");

endmodule

bind aes_wrap_top tb_aes_wrap_assertions u_assertions (
  .clk             (clk),
  .reset_n         (reset_n),
  .seed_load_i     (seed_load_o),
  .kv_req_i        (kv_req_o),
  .key_valid_i     (key_valid_o),
  .clear_secrets_i (clear_secrets_i)
);

// ==== tb_aes_wrap.sv ====
`timescale 1ns/1ps

module tb_aes_wrap;
  import aes_wrap_pkg::*;

  typedef enum logic [2:0] {
    OP_HOST,
    OP_DMA,
    OP_BOTH,
    OP_SEED_CHK,
    OP_KEY_LOAD,
    OP_CLEAR
  } op_e;

  // Table row whose live fields depend on the op
  typedef struct packed {
    op_e        op;
    logic       write;
    addr_t      addr;
    word_t      wdata;
    word_t      exp_rdata;
    logic       exp_err;
    logic [3:0] exp_loads;
    seed_t      exp_seed;
    kv_entry_t  entry;
    key_t       kv_words;
  } step_t;

  logic       clk;
  logic       reset_n;
  cif_req_t   host_req_i;
  cif_req_t   dma_req_i;
  cif_rsp_t   host_rsp_o;
  cif_rsp_t   dma_rsp_o;
  logic       clear_secrets_i;
  logic       kv_req_o;
  kv_entry_t  kv_entry_o;
  logic       kv_wr_en_i;
  logic [2:0] kv_offset_i;
  word_t      kv_data_i;
  logic       kv_done_i;
  logic       key_valid_o;
  key_t       key_o;
  logic       seed_load_o;
  seed_t      seed_o;

  step_t steps[$];
  string names[$];
  int    errors = 0;
  int    cycle_count = 0;
  int    max_cycles = 0;
  int    load_count = 0;
  seed_t last_seed = '0;

  // Expected seed tracker state built along with the table
  seed_t                     seed_model = '0;
  logic [NUM_SEED_WORDS-1:0] seed_flags = '0;
  seed_t                     loaded_model = '0;
  int                        loads_model = 0;

  aes_wrap_top uut (
    .clk             (clk),
    .reset_n         (reset_n),
    .host_req_i      (host_req_i),
    .host_rsp_o      (host_rsp_o),
    .dma_req_i       (dma_req_i),
    .dma_rsp_o       (dma_rsp_o),
    .clear_secrets_i (clear_secrets_i),
    .kv_req_o        (kv_req_o),
    .kv_entry_o      (kv_entry_o),
    .kv_wr_en_i      (kv_wr_en_i),
    .kv_offset_i     (kv_offset_i),
    .kv_data_i       (kv_data_i),
    .kv_done_i       (kv_done_i),
    .key_valid_o     (key_valid_o),
    .key_o           (key_o),
    .seed_load_o     (seed_load_o),
    .seed_o          (seed_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit scales with the table length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (max_cycles > 0 && cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, table not finished", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  // Count load pulses and keep the seed shown with the last one
  always @(negedge clk) begin
    if (reset_n && seed_load_o) begin
      load_count <= load_count + 1;
      last_seed  <= seed_o;
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic word_t swap_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [287:0] exp, input logic [287:0] act);
    assert (exp == act) else begin
      $display("CHECK FAILED %s (%s): expected %0h, actual %0h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic add_access(input string name, input op_e op, input logic write,
                            input addr_t addr, input word_t wdata,
                            input word_t exp_rdata, input logic exp_err);
    step_t s;
    s           = '0;
    s.op        = op;
    s.write     = write;
    s.addr      = addr;
    s.wdata     = wdata;
    s.exp_rdata = exp_rdata;
    s.exp_err   = exp_err;
    steps.push_back(s);
    names.push_back(name);
  endtask

  // Seed write plus the load it should trigger once all nine are set
  task automatic add_seed_write(input string name, input int idx, input op_e port);
    word_t w;
    w = $urandom;
    seed_model[idx*DATA_W +: DATA_W] = w;
    seed_flags[idx] = 1'b1;
    if (&seed_flags) begin
      seed_flags   = '0;
      loads_model  = loads_model + 1;
      loaded_model = seed_model;
    end
    add_access(name, port, 1'b1, addr_t'(ADDR_SEED0 + 4 * idx), w, '0, 1'b0);
  endtask

  task automatic add_special(input string name, input op_e op, input kv_entry_t entry);
    step_t s;
    s           = '0;
    s.op        = op;
    s.entry     = entry;
    s.exp_loads = 4'(loads_model);
    s.exp_seed  = loaded_model;
    for (int i = 0; i < KEY_WORDS; i++) begin
      s.kv_words[i*DATA_W +: DATA_W] = $urandom;
    end
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic build_table();
    word_t wa;
    word_t wb;
    word_t wc;
    word_t wd;
    wa = $urandom;
    wb = $urandom;
    wc = $urandom;
    wd = $urandom;
    // Round trip on both ports and zero from unmapped reads
    add_access("host_wr_din0", OP_HOST, 1'b1, ADDR_DATA_IN0, wa, '0, 1'b0);
    add_access("host_rd_din0", OP_HOST, 1'b0, ADDR_DATA_IN0, '0, wa, 1'b0);
    add_access("dma_wr_din2", OP_DMA, 1'b1, 8'h18, wb, '0, 1'b0);
    add_access("dma_rd_din2", OP_DMA, 1'b0, 8'h18, '0, wb, 1'b0);
    add_access("host_rd_gap", OP_HOST, 1'b0, 8'h0C, '0, '0, 1'b0);
    add_access("dma_rd_unmapped", OP_DMA, 1'b0, 8'h80, '0, '0, 1'b0);
    // Control word reads back as written with the swap on
    add_access("host_wr_ctrl_swap", OP_HOST, 1'b1, ADDR_CTRL0, 32'h1, '0, 1'b0);
    add_access("host_rd_ctrl", OP_HOST, 1'b0, ADDR_CTRL0, '0, 32'h1, 1'b0);
    add_access("host_wr_din3_sw", OP_HOST, 1'b1, ADDR_DATA_IN_LAST, wc, '0, 1'b0);
    add_access("host_rd_din3_sw", OP_HOST, 1'b0, ADDR_DATA_IN_LAST, '0, wc, 1'b0);
    // First seed round with swap still on
    for (int i = 0; i < NUM_SEED_WORDS; i++) begin
      add_seed_write($sformatf("seed_wr%0d", i), i, (i % 2) ? OP_DMA : OP_HOST);
    end
    add_special("seed_load_first", OP_SEED_CHK, '0);
    add_access("host_rd_seed0", OP_HOST, 1'b0, ADDR_SEED0, '0, seed_model[DATA_W-1:0], 1'b0);
    // Stored word shows its swapped form once the swap is off
    add_access("host_wr_ctrl_noswap", OP_HOST, 1'b1, ADDR_CTRL0, 32'h0, '0, 1'b0);
    add_access("host_rd_din3_plain", OP_HOST, 1'b0, ADDR_DATA_IN_LAST, '0, swap_bytes(wc), 1'b0);
    // DMA value wins a collision
    add_access("both_wr_din1", OP_BOTH, 1'b1, 8'h14, wd, '0, 1'b1);
    add_access("host_rd_din1", OP_HOST, 1'b0, 8'h14, '0, wd, 1'b0);
    // Second round with no load before the ninth word
    for (int i = 0; i < NUM_SEED_WORDS - 1; i++) begin
      add_seed_write($sformatf("seed2_wr%0d", i), i, OP_HOST);
    end
    add_special("seed_no_load_at_8", OP_SEED_CHK, '0);
    add_seed_write("seed2_wr8", NUM_SEED_WORDS - 1, OP_DMA);
    add_special("seed_load_second", OP_SEED_CHK, '0);
    add_special("key_load_entry5", OP_KEY_LOAD, 5'd5);
    add_special("key_reload_entry18", OP_KEY_LOAD, 5'd18);
    add_special("clear_secrets", OP_CLEAR, '0);
  endtask

  // ==================================================
  // Step runners
  // ==================================================
  task automatic run_access(input step_t s, input string name);
    cif_req_t req;
    cif_req_t host_req;
    cif_rsp_t rsp;
    req      = '{valid: 1'b1, write: s.write, addr: s.addr, wdata: s.wdata};
    host_req = req;
    // Host sends a different value so the winner is visible
    if (s.op == OP_BOTH) begin
      host_req.wdata = ~s.wdata;
    end
    @(posedge clk);
    if (s.op != OP_DMA) begin
      host_req_i <= host_req;
    end
    if (s.op != OP_HOST) begin
      dma_req_i <= req;
    end
    @(negedge clk);
    rsp = (s.op == OP_DMA) ? dma_rsp_o : host_rsp_o;
    check_value(name, "error", s.exp_err, rsp.error);
    if (!s.write) begin
      check_value(name, "rdata", s.exp_rdata, rsp.rdata);
    end
    if (s.op == OP_BOTH) begin
      check_value(name, "dma error", 1'b1, dma_rsp_o.error);
    end else if (s.op == OP_HOST) begin
      check_value(name, "idle dma rsp", '0, dma_rsp_o);
    end else begin
      check_value(name, "idle host rsp", '0, host_rsp_o);
    end
    @(posedge clk);
    host_req_i <= '0;
    dma_req_i  <= '0;
  endtask

  // Load follows one cycle after the last flag is set
  task automatic run_seed_check(input step_t s, input string name);
    repeat (4) @(negedge clk);
    check_value(name, "load count", s.exp_loads, load_count);
    check_value(name, "seed_o", s.exp_seed, last_seed);
  endtask

  task automatic read_status(input string name, input string what, input word_t exp);
    @(posedge clk);
    host_req_i <= '{valid: 1'b1, write: 1'b0, addr: ADDR_KEY_STATUS, wdata: '0};
    @(negedge clk);
    check_value(name, what, exp, host_rsp_o.rdata);
    @(posedge clk);
    host_req_i <= '0;
  endtask

  task automatic run_key_load(input step_t s, input string name);
    key_t exp_key;
    for (int i = 0; i < KEY_WORDS; i++) begin
      exp_key[i*DATA_W +: DATA_W] = swap_bytes(s.kv_words[i*DATA_W +: DATA_W]);
    end
    // Read enable in bit 0 and entry in bits 5:1
    @(posedge clk);
    host_req_i <= '{valid: 1'b1, write: 1'b1, addr: ADDR_KEY_CTRL,
                    wdata: word_t'({s.entry, 1'b1})};
    @(posedge clk);
    host_req_i <= '0;
    @(negedge clk);
    while (!kv_req_o) begin
      @(negedge clk);
    end
    check_value(name, "kv_entry", s.entry, kv_entry_o);
    check_value(name, "key_valid at request", 1'b0, key_valid_o);
    read_status(name, "status busy", 32'h0);
    // Vault streams eight words and then done
    for (int i = 0; i < KEY_WORDS; i++) begin
      kv_wr_en_i  <= 1'b1;
      kv_offset_i <= 3'(i);
      kv_data_i   <= s.kv_words[i*DATA_W +: DATA_W];
      @(posedge clk);
    end
    kv_wr_en_i <= 1'b0;
    kv_done_i  <= 1'b1;
    @(posedge clk);
    kv_done_i <= 1'b0;
    @(negedge clk);
    while (!key_valid_o) begin
      @(negedge clk);
    end
    check_value(name, "key_o", exp_key, key_o);
    read_status(name, "status done", 32'h3);
  endtask

  task automatic run_clear(input string name);
    @(negedge clk);
    check_value(name, "key_valid before clear", 1'b1, key_valid_o);
    @(posedge clk);
    clear_secrets_i <= 1'b1;
    @(posedge clk);
    clear_secrets_i <= 1'b0;
    @(negedge clk);
    check_value(name, "key_valid after clear", 1'b0, key_valid_o);
    check_value(name, "key_o after clear", '0, key_o);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int errors_before;
    int ok_count;
    void'($urandom(43731));
    ok_count        = 0;
    reset_n         = 1'b0;
    host_req_i      = '0;
    dma_req_i       = '0;
    clear_secrets_i = 1'b0;
    kv_wr_en_i      = 1'b0;
    kv_offset_i     = '0;
    kv_data_i       = '0;
    kv_done_i       = 1'b0;
    build_table();
    max_cycles = steps.size() * 20;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    foreach (steps[i]) begin
      errors_before = errors;
      case (steps[i].op)
        OP_SEED_CHK: run_seed_check(steps[i], names[i]);
        OP_KEY_LOAD: run_key_load(steps[i], names[i]);
        OP_CLEAR:    run_clear(names[i]);
        default:     run_access(steps[i], names[i]);
      endcase
      if (errors == errors_before) begin
        ok_count++;
        $display("[ok]   %s", names[i]);
      end else begin
        $display("[FAIL] %s", names[i]);
      end
    end
    $display("Tests: %0d, ok: %0d, with errors: %0d, check errors: %0d",
             steps.size(), ok_count, steps.size() - ok_count, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
aes_wrap_pkg.sv
aes_req_mux.sv
aes_wrap_regs.sv
aes_seed_tracker.sv
aes_key_loader.sv
aes_wrap_top.sv
tb_aes_wrap_assertions.sv
tb_aes_wrap.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_aes_wrap
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
